//--- files.f
hw/kmcPkg.sv
hw/kmcMaint.sv
hw/kmcSeq.sv
hw/kmcAlu.sv
hw/kmcTop.sv
verif/kmcSeq_properties.sv
verif/kmcTb.sv

//--- verif/kmcTb.sv
module kmcTb;

   import kmcPkg::*;

   localparam logic [15:0] runBit   = 16'h1 << csr0Run;
   localparam logic [15:0] stepBit  = 16'h1 << csr0Step;
   localparam logic [15:0] initBit  = 16'h1 << csr0Init;
   localparam logic [15:0] inBit    = 16'h1 << csr0CramIn;
   localparam logic [15:0] writeBit = (16'h1 << csr0CramOut) | (16'h1 << csr0CramWr);

   logic             clk;
   logic             reset;
   logic             sel0Write;
   logic             sel4Write;
   logic             sel6Write;
   logic [15:0]      dataIn;
   logic [ 7:0]      inPort;
   logic [ 9:0]      pc;
   kmcWord_u         cram;
   logic [ 7:0]      brg;
   logic [ 7:0]      outReg;

   logic [31:0]      lfsr = 32'h857c;
   int               errors = 0;
   int               assertFails;

   kmcTop dut0
   (
      .clk       (clk),
      .reset     (reset),
      .sel0Write (sel0Write),
      .sel4Write (sel4Write),
      .sel6Write (sel6Write),
      .dataIn    (dataIn),
      .inPort    (inPort),
      .pc        (pc),
      .cram      (cram),
      .brg       (brg),
      .outReg    (outReg)
   );

   bind kmcSeq kmcSeqProperties props0 (.*);

   always #2 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   // Galois form with taps 32 22 2 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // One LFSR step per bit
   task automatic randByte(output logic [7:0] value);
      for (int i = 0; i < 8; i++)
      begin
         lfsr     = lfsrNext(lfsr);
         value[i] = lfsr[0];
      end
   endtask

   function automatic logic [15:0] makeAlu(input logic [2:0] src, input logic dest,
                                           input logic [3:0] op, input logic [7:0] imm);
      return {src, dest, op, imm};
   endfunction

   function automatic logic [15:0] makeJump(input logic [2:0] src, input logic [1:0] mar,
                                            input logic [2:0] cond, input logic [7:0] low);
      return {src, mar, cond, low};
   endfunction

   // One strobe cycle from a falling edge
   task automatic hostWrite(input int csr, input logic [15:0] data);
      dataIn    = data;
      sel0Write = (csr == 0);
      sel4Write = (csr == 4);
      sel6Write = (csr == 6);
      @(negedge clk);
      sel0Write = 1'b0;
      sel4Write = 1'b0;
      sel6Write = 1'b0;
   endtask

   // Address, word, then store write
   task automatic loadWord(input logic [9:0] addr, input logic [15:0] word);
      hostWrite(4, {6'd0, addr});
      hostWrite(6, word);
      hostWrite(0, writeBit);
   endtask

   task automatic checkValue(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
      if (expected !== actual)
      begin
         errors++;
         $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic waitPc(input logic [9:0] target, input string name);
      int cycles;
      cycles = 0;
      while (pc !== target && cycles < 200)
      begin
         @(negedge clk);
         cycles++;
      end
      if (pc !== target)
      begin
         errors++;
         $display("Timeout in %s: pc never reached %h", name, target);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      logic [7:0] r;
      logic [7:0] v;
      logic [7:0] d;
      logic [7:0] mTaken;
      logic [7:0] mNot;
      logic [7:0] expOut;
      logic [9:0] pcBefore;
      logic       taken;
      string      name;

      clk       = 1'b0;
      reset     = 1'b1;
      sel0Write = 1'b0;
      sel4Write = 1'b0;
      sel6Write = 1'b0;
      dataIn    = 16'd0;
      inPort    = 8'd0;
      repeat (3) @(negedge clk);
      reset = 1'b0;

      // Reset state at the ports
      checkValue("reset pc", 16'(0), 16'(pc));
      checkValue("reset cram", nopWord, cram);
      checkValue("reset brg", 16'(0), 16'(brg));
      checkValue("reset outReg", 16'(0), 16'(outReg));

      // Halt loops jump to self with a nop delay slot
      loadWord(10'h005, makeJump(srcJmpImmed, 2'd0, condAlways, 8'h05));
      loadWord(10'h006, nopWord);
      loadWord(10'h121, makeJump(srcJmpImmed, 2'd1, condAlways, 8'h21));
      loadWord(10'h122, nopWord);

      // Every condition with flags and brg bits set then cleared
      for (int c = 0; c < 8; c++)
      begin
         for (int pol = 0; pol < 2; pol++)
         begin
            randByte(r);
            randByte(d);
            randByte(mTaken);
            randByte(mNot);
            // brg bits 0 1 4 7 all set or all clear
            v = (pol == 1) ? (r | 8'h93) : (r & 8'h6C);
            loadWord(10'h000, makeAlu(srcAluImmed, destBrg, opPassB, v));
            // v minus v sets C and Z
            // v plus 1 clears both as v is at most 6C
            if (pol == 1)
            begin
               loadWord(10'h001, makeAlu(srcAluImmed, destOut, opSub, v));
            end
            else
            begin
               loadWord(10'h001, makeAlu(srcAluImmed, destOut, opAdd, 8'h01));
            end
            loadWord(10'h002, makeJump(srcJmpImmed, 2'd1, 3'(c), 8'h20));
            // Delay slot
            loadWord(10'h003, makeAlu(srcAluImmed, destBrg, opAdd, d));
            loadWord(10'h004, makeAlu(srcAluImmed, destOut, opXor, mNot));
            loadWord(10'h120, makeAlu(srcAluImmed, destOut, opXor, mTaken));

            taken  = (c < 2) || (pol == 1);
            expOut = (v + d) ^ (taken ? mTaken : mNot);
            name   = $sformatf("branch cond %0d pol %0d", c, pol);

            hostWrite(0, initBit);
            hostWrite(0, runBit);
            waitPc(taken ? 10'h121 : 10'h005, name);
            repeat (4) @(negedge clk);
            hostWrite(0, 16'd0);
            checkValue(name, 16'(expOut), 16'(outReg));
         end
      end

      // Init clears processor state
      // brg and outReg are nonzero here
      hostWrite(0, initBit);
      @(negedge clk);
      checkValue("init pc", 16'(0), 16'(pc));
      checkValue("init cram", nopWord, cram);
      checkValue("init brg", 16'(0), 16'(brg));
      checkValue("init outReg", 16'(0), 16'(outReg));

      // Single step moves pc once
      pcBefore = pc;
      hostWrite(0, stepBit);
      repeat (2) @(negedge clk);
      checkValue("single step pc", 16'(pcBefore + 10'd1), 16'(pc));

      // Maintenance word copies inPort to outReg
      randByte(inPort);
      hostWrite(6, makeAlu(srcAluIn, destOut, opPassB, 8'h00));
      hostWrite(0, inBit | stepBit);
      // Its step moves pc once more
      waitPc(pcBefore + 10'd2, "maintenance step");
      checkValue("maintenance step", 16'(inPort), 16'(outReg));
      hostWrite(0, 16'd0);
      repeat (2) @(negedge clk);

      assertFails = dut0.seq0.props0.failCount;
      $display("Checks failed: %0d, assertions failed: %0d", errors, assertFails);
      if (errors == 0 && assertFails == 0)
      begin
         $display("Verification passed");
      end
      else
      begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- verif/kmcSeq_properties.sv
module kmcSeqProperties
(
   input  logic               clk,
   input  logic               reset,
   input  logic               init,
   input  logic               advance,
   input  logic               cramIn,
   input  logic               cramWrite,
   input  logic [ 9:0]        maintAddr,
   input  logic [15:0]        maintInst,
   input  logic               aluC,
   input  logic               aluZ,
   input  logic [ 7:0]        brg,
   input  logic [ 9:0]        pc,
   input  kmcPkg::kmcWord_u   cram
);

   import kmcPkg::*;

   int          failCount = 0;
   logic [15:0] shadow [0:1023];   // Copy of every store write
   logic [15:0] shadowWord;
   logic        condMet;
   logic        jumpTaken;
   logic [ 7:0] lowTarget;
   logic [ 9:0] nextPc;

   ////////////////////////////////////////////////////////////////////////////
   // Reference model of store and next PC
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (cramWrite)
      begin
         shadow[maintAddr] <= maintInst;
      end
   end

   // Word the IR should fetch at this PC
   assign shadowWord = shadow[pc];

   always_comb
   begin
      // Condition table, codes 0 and 1 always taken
      case (cram.jmp.cond)
         3'd2    : condMet = aluC;
         3'd3    : condMet = aluZ;
         3'd4    : condMet = brg[0];
         3'd5    : condMet = brg[1];
         3'd6    : condMet = brg[4];
         3'd7    : condMet = brg[7];
         default : condMet = 1'b1;
      endcase
      jumpTaken = ((cram.jmp.src == 3'd4) || (cram.jmp.src == 3'd6)) && condMet;
      // Low target from brg only for the brg jump source
      lowTarget = (cram.jmp.src == 3'd6) ? brg : cram.jmp.target;
      nextPc    = jumpTaken ? {cram.jmp.mar, lowTarget} : pc + 10'd1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   // Reset and init clear PC, IR and brg
   clearState: assert property (@(posedge clk)
      (reset || init) |=> (pc == 10'd0) && (brg == 8'd0) && (cramIn || cram === nopWord))
      else begin failCount++; $error("pc, cram or brg not cleared"); end

   // Step or load on advance
   pcNext: assert property (@(posedge clk) disable iff (reset)
      (advance && !init) |=> pc == $past(nextPc))
      else begin failCount++; $error("pc did not follow its next value rule"); end

   // No advance, no PC change
   pcHold: assert property (@(posedge clk) disable iff (reset)
      (!advance && !init) |=> pc == $past(pc))
      else begin failCount++; $error("pc changed without advance"); end

   // IR holds too
   irHold: assert property (@(posedge clk) disable iff (reset)
      (!advance && !init && !cramIn) |=> cramIn || (cram === $past(cram)))
      else begin failCount++; $error("cram changed without advance"); end

   // Prefetch returns the word last written at the old PC
   irFetch: assert property (@(posedge clk) disable iff (reset)
      (advance && !init) |=> cramIn || (cram === $past(shadowWord)))
      else begin failCount++; $error("cram differs from the word stored at old pc"); end

   // Maintenance word overrides
   maintMux: assert property (@(posedge clk) disable iff (reset)
      cramIn |-> cram === maintInst)
      else begin failCount++; $error("cram does not show maintInst"); end

endmodule

//--- hw/kmcTop.sv
module kmcTop
(
   input  logic               clk,
   input  logic               reset,
   input  logic               sel0Write,   // CSR0 write strobe
   input  logic               sel4Write,   // CSR4 write strobe
   input  logic               sel6Write,   // CSR6 write strobe
   input  logic [15:0]        dataIn,      // Host write data
   input  logic [ 7:0]        inPort,      // External input port
   output logic [ 9:0]        pc,
   output kmcPkg::kmcWord_u   cram,
   output logic [ 7:0]        brg,
   output logic [ 7:0]        outReg
);

   // Maintenance to sequencer
   logic [ 9:0] maintAddr;
   logic [15:0] maintInst;
   logic        cramIn;
   logic        cramWrite;
   logic        init;
   logic        advance;

   // ALU to sequencer
   logic [ 7:0] branchLow;
   logic        aluC;
   logic        aluZ;

   // Register block, cramOut is host status only
   kmcMaint maint0
   (
      .clk       (clk),
      .reset     (reset),
      .sel0Write (sel0Write),
      .sel4Write (sel4Write),
      .sel6Write (sel6Write),
      .dataIn    (dataIn),
      .maintAddr (maintAddr),
      .maintInst (maintInst),
      .cramIn    (cramIn),
      .cramOut   (),
      .cramWrite (cramWrite),
      .init      (init),
      .advance   (advance)
   );

   // PC, store and IR
   kmcSeq seq0
   (
      .clk       (clk),
      .reset     (reset),
      .init      (init),
      .advance   (advance),
      .cramIn    (cramIn),
      .cramWrite (cramWrite),
      .maintAddr (maintAddr),
      .maintInst (maintInst),
      .branchLow (branchLow),
      .aluC      (aluC),
      .aluZ      (aluZ),
      .brg       (brg),
      .pc        (pc),
      .cram      (cram)
   );

   // Datapath
   kmcAlu alu0
   (
      .clk       (clk),
      .reset     (reset),
      .init      (init),
      .advance   (advance),
      .cram      (cram),
      .inPort    (inPort),
      .branchLow (branchLow),
      .aluC      (aluC),
      .aluZ      (aluZ),
      .brg       (brg),
      .outReg    (outReg)
   );

endmodule

//--- hw/kmcAlu.sv
module kmcAlu
(
   input  logic               clk,
   input  logic               reset,
   input  logic               init,        // Processor clear
   input  logic               advance,     // Register enable
   input  kmcPkg::kmcWord_u   cram,        // Current microword
   input  logic [7:0]         inPort,      // External input
   output logic [7:0]         branchLow,   // Low jump target
   output logic               aluC,        // Carry flag
   output logic               aluZ,        // Zero flag
   output logic [7:0]         brg,         // Branch register
   output logic [7:0]         outReg       // Output register
);

   import kmcPkg::*;

   logic [7:0] opA;
   logic [7:0] opB;
   logic [8:0] result;     // Carry in bit 8
   logic       aluWord;

   ////////////////////////////////////////////////////////////////////////////
   // Operand select
   ////////////////////////////////////////////////////////////////////////////

   // A side fixed
   assign opA = brg;

   // B side by source
   always_comb
   begin
      case (cram.alu.src)
         srcAluBrg : opB = brg;
         srcAluIn  : opB = inPort;
         default   : opB = cram.alu.imm;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // ALU function
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      case (cram.alu.aluOp)
         opPassB : result = {1'b0, opB};
         opAdd   : result = {1'b0, opA} + {1'b0, opB};
         // Two's complement add, carry out is no borrow
         opSub   : result = {1'b0, opA} + {1'b0, ~opB} + 9'd1;
         opAnd   : result = {1'b0, opA & opB};
         opOr    : result = {1'b0, opA | opB};
         opXor   : result = {1'b0, opA ^ opB};
         // Bit 0 falls into carry
         opShr   : result = {opA[0], 1'b0, opA[7:1]};
         opIncA  : result = {1'b0, opA} + 9'd1;
         default : result = {1'b0, opB};
      endcase
   end

   // Jumps and nops leave all registers alone
   assign aluWord = isAluFmt(cram.alu.src);

   ////////////////////////////////////////////////////////////////////////////
   // Result registers and flags
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset | init)
      begin
         brg    <= 8'd0;
         outReg <= 8'd0;
         aluC   <= 1'b0;
         aluZ   <= 1'b0;
      end
      else if (advance & aluWord)
      begin
         if (cram.alu.dest == destOut)
         begin
            outReg <= result[7:0];
         end
         else
         begin
            brg <= result[7:0];
         end
         // Flags from every ALU word, either destination
         aluC <= result[8];
         aluZ <= (result[7:0] == 8'd0);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Jump target
   ////////////////////////////////////////////////////////////////////////////

   // Offset from brg or from the word itself
   assign branchLow = (cram.jmp.src == srcJmpBrg) ? brg : cram.jmp.target;

endmodule

//--- hw/kmcSeq.sv
module kmcSeq
(
   input  logic               clk,
   input  logic               reset,
   input  logic               init,        // Processor clear
   input  logic               advance,     // PC and IR enable
   input  logic               cramIn,      // Show maintInst on cram
   input  logic               cramWrite,   // Store write pulse
   input  logic [ 9:0]        maintAddr,
   input  logic [15:0]        maintInst,
   input  logic [ 7:0]        branchLow,   // Low target from the ALU block
   input  logic               aluC,
   input  logic               aluZ,
   input  logic [ 7:0]        brg,
   output logic [ 9:0]        pc,
   output kmcPkg::kmcWord_u   cram         // Word being executed
);

   import kmcPkg::*;

   logic [15:0] store [0:1023];
   kmcWord_u    instReg;
   logic        jmpWord;
   logic        taken;

   ////////////////////////////////////////////////////////////////////////////
   // Branch decode
   ////////////////////////////////////////////////////////////////////////////

   // Only the two jump sources may load the PC
   assign jmpWord = isJump(cram.jmp.src);

   // Condition against flags and branch register bits
   always_comb
   begin
      case (cram.jmp.cond)
         condResvd  : taken = 1'b1;
         condAlways : taken = 1'b1;
         condAluC   : taken = aluC;
         condAluZ   : taken = aluZ;
         condBrg0   : taken = brg[0];
         condBrg1   : taken = brg[1];
         condBrg4   : taken = brg[4];
         condBrg7   : taken = brg[7];
         default    : taken = 1'b1;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Program counter
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset | init)
      begin
         pc <= 10'd0;
      end
      else if (advance)
      begin
         if (jmpWord & taken)
         begin
            // Page from mar, offset from word or brg
            pc <= {cram.jmp.mar, branchLow};
         end
         else
         begin
            pc <= pc + 10'd1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Control store
   ////////////////////////////////////////////////////////////////////////////

   // Maintenance write port
   always_ff @(posedge clk)
   begin
      if (cramWrite)
      begin
         store[maintAddr] <= maintInst;
      end
   end

   // Prefetch with the old PC
   // Word after a taken jump still runs, one delay slot
   always_ff @(posedge clk)
   begin
      if (reset | init)
      begin
         instReg <= nopWord;
      end
      else if (advance)
      begin
         instReg <= store[pc];
      end
   end

   // Maintenance instruction overrides the IR
   assign cram = cramIn ? maintInst : instReg;

endmodule

//--- hw/kmcMaint.sv
module kmcMaint
(
   input  logic        clk,
   input  logic        reset,
   input  logic        sel0Write,   // CSR0 write strobe
   input  logic        sel4Write,   // CSR4 write strobe
   input  logic        sel6Write,   // CSR6 write strobe
   input  logic [15:0] dataIn,      // Host write data
   output logic [ 9:0] maintAddr,   // CSR4
   output logic [15:0] maintInst,   // CSR6
   output logic        cramIn,
   output logic        cramOut,
   output logic        cramWrite,   // Store write pulse
   output logic        init,        // Processor clear pulse
   output logic        advance      // Sequencer clock enable
);

   import kmcPkg::*;

   logic run;
   logic stepPulse;

   ////////////////////////////////////////////////////////////////////////////
   // Maintenance address and instruction
   ////////////////////////////////////////////////////////////////////////////

   // Host data only, init leaves these alone
   always_ff @(posedge clk)
   begin
      if (sel4Write)
      begin
         maintAddr <= dataIn[9:0];
      end
      if (sel6Write)
      begin
         maintInst <= dataIn;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // CSR0 levels
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         run     <= 1'b0;
         cramIn  <= 1'b0;
         cramOut <= 1'b0;
      end
      else if (sel0Write)
      begin
         run     <= dataIn[csr0Run];
         cramIn  <= dataIn[csr0CramIn];
         cramOut <= dataIn[csr0CramOut];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // CSR0 pulses
   ////////////////////////////////////////////////////////////////////////////

   // Each pulse lasts the single cycle after the write
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         stepPulse <= 1'b0;
         init      <= 1'b0;
         cramWrite <= 1'b0;
      end
      else
      begin
         stepPulse <= sel0Write & dataIn[csr0Step];
         init      <= sel0Write & dataIn[csr0Init];
         // Store write needs both out and write bits in the same word
         cramWrite <= sel0Write & dataIn[csr0CramOut] & dataIn[csr0CramWr];
      end
   end

   // Free run, or one shot from step
   assign advance = run | stepPulse;

endmodule

//--- hw/kmcPkg.sv
package kmcPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Microword formats
   ////////////////////////////////////////////////////////////////////////////

   // Jump view
   typedef struct packed
   {
      logic [2:0] src;       // Source select, 15:13
      logic [1:0] mar;       // High PC bits of the target
      logic [2:0] cond;      // Branch condition
      logic [7:0] target;    // Low target when taken from the word
   } kmcJmp_t;

   // ALU view
   typedef struct packed
   {
      logic [2:0] src;       // Source select, 15:13
      logic       dest;      // Destination register
      logic [3:0] aluOp;     // ALU function
      logic [7:0] imm;       // Immediate B operand
   } kmcAluFmt_t;

   // Same 16 bits, decoded by src
   typedef union packed
   {
      kmcJmp_t    jmp;
      kmcAluFmt_t alu;
   } kmcWord_u;

   ////////////////////////////////////////////////////////////////////////////
   // Field codes
   ////////////////////////////////////////////////////////////////////////////

   // Source codes; 3 and 5 decode as nop
   localparam logic [2:0] srcAluImmed = 3'd0;
   localparam logic [2:0] srcAluBrg   = 3'd1;
   localparam logic [2:0] srcAluIn    = 3'd2;
   localparam logic [2:0] srcJmpImmed = 3'd4;
   localparam logic [2:0] srcJmpBrg   = 3'd6;
   localparam logic [2:0] srcNop      = 3'd7;

   // Branch conditions
   localparam logic [2:0] condResvd  = 3'd0;
   localparam logic [2:0] condAlways = 3'd1;
   localparam logic [2:0] condAluC   = 3'd2;
   localparam logic [2:0] condAluZ   = 3'd3;
   localparam logic [2:0] condBrg0   = 3'd4;
   localparam logic [2:0] condBrg1   = 3'd5;
   localparam logic [2:0] condBrg4   = 3'd6;
   localparam logic [2:0] condBrg7   = 3'd7;

   // Destination of an ALU word
   localparam logic destBrg = 1'b0;
   localparam logic destOut = 1'b1;

   // ALU functions, A is always the branch register
   localparam logic [3:0] opPassB = 4'd0;
   localparam logic [3:0] opAdd   = 4'd1;
   localparam logic [3:0] opSub   = 4'd2;   // Carry set means no borrow
   localparam logic [3:0] opAnd   = 4'd3;
   localparam logic [3:0] opOr    = 4'd4;
   localparam logic [3:0] opXor   = 4'd5;
   localparam logic [3:0] opShr   = 4'd6;   // Carry gets bit shifted out
   localparam logic [3:0] opIncA  = 4'd7;

   // Idle word, loaded into the IR on reset and init
   localparam logic [15:0] nopWord = {srcNop, 13'd0};

   // CSR0 bit positions
   localparam int csr0Run     = 0;
   localparam int csr0Step    = 1;
   localparam int csr0Init    = 2;
   localparam int csr0CramIn  = 3;
   localparam int csr0CramOut = 4;
   localparam int csr0CramWr  = 5;

   // Word is a jump
   function automatic logic isJump(input logic [2:0] src);
      return (src == srcJmpImmed) || (src == srcJmpBrg);
   endfunction

   // Word is in the ALU format
   function automatic logic isAluFmt(input logic [2:0] src);
      return (src == srcAluImmed) || (src == srcAluBrg) || (src == srcAluIn);
   endfunction

endpackage
